/* verilog.f */
rtl/dma_pkg.sv
rtl/mem_pkg.sv
rtl/dma_fifo.sv
rtl/dma_request_path.sv
rtl/dma_response_path.sv
rtl/dma_to_mem_bridge.sv
verification/tb_dma_to_mem_bridge.sv

/* Makefile */
# Verilator build and run for the DMA to memory bridge

SRCS := $(shell cat verilog.f)
BIN  := build/Vtb_dma_to_mem_bridge

.PHONY: all run clean

all: run

$(BIN): $(SRCS) verilog.f
	verilator --binary --timing --assert -f verilog.f \
	  --top-module tb_dma_to_mem_bridge -Mdir build

run: $(BIN)
	./$(BIN) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf build sim.log

/* verification/tb_dma_to_mem_bridge.sv */
// Directed testbench for the cache DMA to memory bridge
// A behavioral memory answers commands in order after random delays;
// each test task drives the cache ports and checks the returned words
`timescale 1ns/1ns
`default_nettype none

module tb_dma_to_mem_bridge
  import dma_pkg::*;
  import mem_pkg::*;
;

  localparam int TIMEOUT = 400;

  logic                                 clk_i;
  logic                                 reset_i;
  dma_pkt_s [NUM_PORTS-1:0]             dma_pkt_i;
  logic [NUM_PORTS-1:0]                 dma_pkt_v_i;
  logic [NUM_PORTS-1:0]                 dma_pkt_yumi_o;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] dma_data_i;
  logic [NUM_PORTS-1:0]                 dma_data_v_i;
  logic [NUM_PORTS-1:0]                 dma_data_yumi_o;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] dma_data_o;
  logic [NUM_PORTS-1:0]                 dma_data_v_o;
  logic [NUM_PORTS-1:0]                 dma_data_ready_i;
  mem_msg_s                             mem_cmd_o;
  logic                                 mem_cmd_v_o;
  logic                                 mem_cmd_yumi_i;
  mem_msg_s                             mem_resp_i;
  logic                                 mem_resp_v_i;
  logic                                 mem_resp_ready_o;

  int                          errors;
  int                          delay;
  logic                        resp_fire;
  logic [BLOCK_WIDTH-1:0]      mem_a [logic [MEM_ADDR_WIDTH-1:0]];
  mem_msg_s                    resp_q [$];
  logic [MEM_ADDR_WIDTH-1:0]   cmd_log [$];
  logic [DATA_WIDTH-1:0]       got [NUM_PORTS][$];
  int                          valid_cycles [NUM_PORTS];

  dma_to_mem_bridge UUT (.*);

  always #10 clk_i = ~clk_i;

  // Port number goes just above the block offset
  function automatic logic [MEM_ADDR_WIDTH-1:0] mem_addr(input int p, input logic [15:0] a);
    return {a[15:4], 1'(p), a[3:0]};
  endfunction

  // Unwritten blocks read back a pattern built from the whole address
  function automatic logic [BLOCK_WIDTH-1:0] block_at(input logic [MEM_ADDR_WIDTH-1:0] a);
    if (mem_a.exists(a))
      return mem_a[a];
    return {4{32'(a) ^ 32'h5a000000}} ^ {32'd3, 32'd2, 32'd1, 32'd0};
  endfunction

  // Behavioral memory, commands taken after a random delay
  initial
  begin
    mem_msg_s r;
    mem_cmd_yumi_i = 1'b0;
    mem_resp_v_i   = 1'b0;
    mem_resp_i     = '0;
    resp_fire      = 1'b0;
    delay          = 0;
    forever
    begin
      @(negedge clk_i);
      if (resp_fire)
        void'(resp_q.pop_front());
      mem_cmd_yumi_i = 1'b0;
      if (!reset_i && mem_cmd_v_o)
      begin
        if (delay == 0)
        begin
          mem_cmd_yumi_i = 1'b1;
          cmd_log.push_back(mem_cmd_o.addr);
          r          = mem_cmd_o;
          if (mem_cmd_o.msg_type == MEM_WRITE)
          begin
            mem_a[mem_cmd_o.addr] = mem_cmd_o.data;
            r.data = '0;
          end
          else
          begin
            if (mem_cmd_o.data !== '0)
            begin
              $display("Fail %0t mem_cmd_o.data got %h expected %h", $time,
                       mem_cmd_o.data, {BLOCK_WIDTH{1'b0}});
              errors++;
            end
            r.data = block_at(mem_cmd_o.addr);
          end
          resp_q.push_back(r);
          delay = $urandom % 4;
        end
        else
          delay--;
      end
      mem_resp_v_i = !reset_i && (resp_q.size() > 0);
      if (mem_resp_v_i)
        mem_resp_i = resp_q[0];
      resp_fire = mem_resp_v_i & mem_resp_ready_o;
    end
  end

  // Read-data monitor, runs after the stimulus of each falling edge
  always @(negedge clk_i)
  begin
    #2;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (dma_data_v_o[p])
        valid_cycles[p]++;
      if (dma_data_v_o[p] && dma_data_ready_i[p])
        got[p].push_back(dma_data_o[p]);
    end
  end

  task automatic send_pkt(input logic [NUM_PORTS-1:0] ports, input logic wnr,
                          input logic [15:0] a0, input logic [15:0] a1);
    int t;
    @(negedge clk_i);
    dma_pkt_i[0] = '{write_not_read: wnr, addr: a0};
    dma_pkt_i[1] = '{write_not_read: wnr, addr: a1};
    dma_pkt_v_i  = ports;
    for (t = 0; t < TIMEOUT; t++)
    begin
      #1;
      if ((dma_pkt_yumi_o & ports) == ports)
        break;
      @(negedge clk_i);
    end
    if (t == TIMEOUT)
    begin
      $display("Timeout waiting for packet yumi at %0t", $time);
      errors++;
    end
    @(negedge clk_i);
    dma_pkt_v_i = '0;
  endtask

  task automatic send_block(input int p, input logic [BLOCK_WIDTH-1:0] blk);
    int t;
    for (int i = 0; i < WORDS_PER_BLOCK; i++)
    begin
      dma_data_i[p]   = blk[i*DATA_WIDTH +: DATA_WIDTH];
      dma_data_v_i[p] = 1'b1;
      for (t = 0; t < TIMEOUT; t++)
      begin
        #1;
        if (dma_data_yumi_o[p])
          break;
        @(negedge clk_i);
      end
      if (t == TIMEOUT)
      begin
        $display("Timeout waiting for write data yumi on port %0d", p);
        errors++;
      end
      @(negedge clk_i);
    end
    dma_data_v_i[p] = 1'b0;
  endtask

  task automatic write_block(input int p, input logic [15:0] a, input logic [BLOCK_WIDTH-1:0] blk);
    send_pkt(2'(1 << p), 1'b1, a, a);
    send_block(p, blk);
  endtask

  // Waits for a block and compares it word by word, low word first
  task automatic check_block(input int p, input logic [BLOCK_WIDTH-1:0] blk);
    int t;
    logic [DATA_WIDTH-1:0] w;
    for (t = 0; t < TIMEOUT && got[p].size() < WORDS_PER_BLOCK; t++)
      @(negedge clk_i);
    if (t == TIMEOUT)
    begin
      $display("Timeout waiting for read data on port %0d", p);
      errors++;
      got[p].delete();
      return;
    end
    for (int i = 0; i < WORDS_PER_BLOCK; i++)
    begin
      w = got[p].pop_front();
      if (w !== blk[i*DATA_WIDTH +: DATA_WIDTH])
      begin
        $display("Fail %0t dma_data_o[%0d] got %h expected %h", $time, p, w,
                 blk[i*DATA_WIDTH +: DATA_WIDTH]);
        errors++;
      end
    end
  endtask

  task automatic test_reset_state();
    if (mem_cmd_v_o || dma_pkt_yumi_o || dma_data_yumi_o || dma_data_v_o)
    begin
      $display("Outputs not low after reset at %0t", $time);
      errors++;
    end
  endtask

  task automatic test_write_read();
    logic [BLOCK_WIDTH-1:0] blk = 128'h44444444_33333333_22222222_11111111;
    write_block(0, 16'h0040, blk);
    send_pkt(2'b01, 1'b0, 16'h0040, 16'h0040);
    check_block(0, blk);
    if (got[1].size() != 0)
    begin
      $display("Read data for port 0 appeared on port 1");
      errors++;
    end
  endtask

  task automatic test_same_addr();
    logic [BLOCK_WIDTH-1:0] b0 = 128'ha0a0a0a3_a0a0a0a2_a0a0a0a1_a0a0a0a0;
    logic [BLOCK_WIDTH-1:0] b1 = 128'hb1b1b1b3_b1b1b1b2_b1b1b1b1_b1b1b1b0;
    write_block(0, 16'h0120, b0);
    write_block(1, 16'h0120, b1);
    send_pkt(2'b01, 1'b0, 16'h0120, 16'h0120);
    send_pkt(2'b10, 1'b0, 16'h0120, 16'h0120);
    check_block(0, b0);
    check_block(1, b1);
  endtask

  task automatic test_round_robin();
    int n;
    send_pkt(2'b11, 1'b0, 16'h0200, 16'h0300);
    send_pkt(2'b11, 1'b0, 16'h0210, 16'h0310);
    check_block(0, block_at(mem_addr(0, 16'h0200)));
    check_block(0, block_at(mem_addr(0, 16'h0210)));
    check_block(1, block_at(mem_addr(1, 16'h0300)));
    check_block(1, block_at(mem_addr(1, 16'h0310)));
    n = cmd_log.size();
    for (int i = n - 4; i < n - 1; i++)
      if (cmd_log[i][4] == cmd_log[i+1][4])
      begin
        $display("Memory commands did not alternate between ports");
        errors++;
      end
  endtask

  task automatic test_stall();
    int t;
    send_pkt(2'b01, 1'b0, 16'h0400, 16'h0400);
    send_pkt(2'b01, 1'b0, 16'h0410, 16'h0410);
    for (t = 0; t < TIMEOUT && got[0].size() < 2; t++)
      @(negedge clk_i);
    if (t == TIMEOUT)
    begin
      $display("Timeout waiting for the first words of the stalled block");
      errors++;
    end
    dma_data_ready_i[0] = 1'b0;
    repeat ($urandom % 8 + 2) @(negedge clk_i);
    dma_data_ready_i[0] = 1'b1;
    check_block(0, block_at(mem_addr(0, 16'h0400)));
    check_block(0, block_at(mem_addr(0, 16'h0410)));
  endtask

  task automatic test_write_reply();
    int v0;
    int v1;
    int t;
    v0 = valid_cycles[0];
    v1 = valid_cycles[1];
    write_block(0, 16'h0500, {4{32'hc0de0000}});
    write_block(1, 16'h0600, {4{32'hc0de0001}});
    for (t = 0; t < TIMEOUT && (resp_q.size() != 0 || mem_cmd_v_o); t++)
      @(negedge clk_i);
    if (t == TIMEOUT)
    begin
      $display("Timeout waiting for the write replies to drain");
      errors++;
    end
    repeat (4) @(negedge clk_i);
    if (valid_cycles[0] != v0 || valid_cycles[1] != v1)
    begin
      $display("Write replies produced read data valid");
      errors++;
    end
  endtask

  initial
  begin
    void'($urandom(32'hc4424319));
    errors           = 0;
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    dma_pkt_i        = '0;
    dma_pkt_v_i      = '1;
    dma_data_i       = '0;
    dma_data_v_i     = '1;
    dma_data_ready_i = '1;
    valid_cycles     = '{0, 0};
    // Valids are high during reset, so any yumi here is a real fault
    repeat (2) @(negedge clk_i);
    if (mem_resp_ready_o || dma_pkt_yumi_o || dma_data_yumi_o)
    begin
      $display("Ready or yumi high during reset");
      errors++;
    end
    @(negedge clk_i);
    reset_i      = 1'b0;
    dma_pkt_v_i  = '0;
    dma_data_v_i = '0;
    test_reset_state();
    test_write_read();
    test_same_addr();
    test_round_robin();
    test_stall();
    test_write_reply();
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/dma_to_mem_bridge.sv */
// Top level of the cache DMA to memory bridge
// Request and response halves run side by side; the read-order queue
// carries the port of each read in flight from one half to the other
`timescale 1ns/1ns
`default_nettype none

module dma_to_mem_bridge
  import dma_pkg::*;
  import mem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  dma_pkt_s [NUM_PORTS-1:0]              dma_pkt_i,
  input  logic [NUM_PORTS-1:0]                  dma_pkt_v_i,
  output logic [NUM_PORTS-1:0]                  dma_pkt_yumi_o,
  input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  dma_data_i,
  input  logic [NUM_PORTS-1:0]                  dma_data_v_i,
  output logic [NUM_PORTS-1:0]                  dma_data_yumi_o,
  output logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  dma_data_o,
  output logic [NUM_PORTS-1:0]                  dma_data_v_o,
  input  logic [NUM_PORTS-1:0]                  dma_data_ready_i,
  output mem_msg_s                              mem_cmd_o,
  output logic                                  mem_cmd_v_o,
  input  logic                                  mem_cmd_yumi_i,
  input  mem_msg_s                              mem_resp_i,
  input  logic                                  mem_resp_v_i,
  output logic                                  mem_resp_ready_o
);

  logic     order_ready;
  logic     order_push;
  port_id_t order_port;
  port_id_t order_head;
  logic     order_v;
  logic     order_pop;

  dma_request_path u_request_path (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .dma_pkt_i       (dma_pkt_i),
    .dma_pkt_v_i     (dma_pkt_v_i),
    .dma_pkt_yumi_o  (dma_pkt_yumi_o),
    .dma_data_i      (dma_data_i),
    .dma_data_v_i    (dma_data_v_i),
    .dma_data_yumi_o (dma_data_yumi_o),
    .order_ready_i   (order_ready),
    .order_push_o    (order_push),
    .order_port_o    (order_port),
    .mem_cmd_o       (mem_cmd_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_yumi_i  (mem_cmd_yumi_i)
  );

  // Up to four reads in flight
  dma_fifo #(
    .payload_t (port_id_t),
    .DEPTH     (4)
  ) u_order_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (order_port),
    .v_i     (order_push),
    .ready_o (order_ready),
    .data_o  (order_head),
    .v_o     (order_v),
    .yumi_i  (order_pop)
  );

  dma_response_path u_response_path (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .mem_resp_i       (mem_resp_i),
    .mem_resp_v_i     (mem_resp_v_i),
    .mem_resp_ready_o (mem_resp_ready_o),
    .order_port_i     (order_head),
    .order_v_i        (order_v),
    .order_pop_o      (order_pop),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

endmodule

`default_nettype wire

/* rtl/dma_response_path.sv */
// Response half of the bridge
// Buffers memory responses, drops write replies and returns each read
// block word by word to the port at the head of the order queue
`timescale 1ns/1ns
`default_nettype none

module dma_response_path
  import dma_pkg::*;
  import mem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  mem_msg_s                              mem_resp_i,
  input  logic                                  mem_resp_v_i,
  output logic                                  mem_resp_ready_o,
  input  port_id_t                              order_port_i,
  input  logic                                  order_v_i,
  output logic                                  order_pop_o,
  output logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  dma_data_o,
  output logic [NUM_PORTS-1:0]                  dma_data_v_o,
  input  logic [NUM_PORTS-1:0]                  dma_data_ready_i
);

  localparam int CNT_W = $clog2(WORDS_PER_BLOCK);

  mem_msg_s               resp_head;
  logic                   resp_v;
  logic                   resp_yumi;
  logic                   is_read;
  logic                   load;
  logic                   fire;
  logic                   full_r;
  logic [CNT_W-1:0]       count_r;
  logic [BLOCK_WIDTH-1:0] shift_r;

  dma_fifo #(
    .payload_t (mem_msg_s),
    .DEPTH     (2)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (mem_resp_i),
    .v_i     (mem_resp_v_i),
    .ready_o (mem_resp_ready_o),
    .data_o  (resp_head),
    .v_o     (resp_v),
    .yumi_i  (resp_yumi)
  );

  assign is_read = (resp_head.msg_type == MEM_READ);
  assign load    = resp_v & is_read & ~full_r;

  // Write replies are popped straight away
  assign resp_yumi = resp_v & (~is_read | ~full_r);

  assign fire        = full_r & dma_data_ready_i[order_port_i];
  assign order_pop_o = fire & (count_r == CNT_W'(WORDS_PER_BLOCK - 1));

  // Data is shared by all ports, valid only at the requester
  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
      dma_data_o[p] = shift_r[DATA_WIDTH-1:0];
    dma_data_v_o               = '0;
    dma_data_v_o[order_port_i] = full_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      full_r  <= 1'b0;
      count_r <= '0;
    end
    else if (load)
    begin
      full_r  <= 1'b1;
      count_r <= '0;
    end
    else if (fire)
    begin
      count_r <= count_r + 1'b1;
      if (order_pop_o)
        full_r <= 1'b0;
    end
  end

  // Low word leaves first
  always_ff @(posedge clk_i)
  begin
    if (load)
      shift_r <= resp_head.data;
    else if (fire)
      shift_r <= shift_r >> DATA_WIDTH;
  end

  // Every read block needs its port logged by the request half
  assert property (@(posedge clk_i) disable iff (reset_i) load |-> order_v_i);

endmodule

`default_nettype wire

/* rtl/dma_request_path.sv */
// Request half of the bridge
// Arbitrates DMA packets round-robin, gathers write blocks and forms one
// memory command per packet; reads also log their port in the order queue
`timescale 1ns/1ns
`default_nettype none

module dma_request_path
  import dma_pkg::*;
  import mem_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  dma_pkt_s [NUM_PORTS-1:0]              dma_pkt_i,
  input  logic [NUM_PORTS-1:0]                  dma_pkt_v_i,
  output logic [NUM_PORTS-1:0]                  dma_pkt_yumi_o,
  input  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0]  dma_data_i,
  input  logic [NUM_PORTS-1:0]                  dma_data_v_i,
  output logic [NUM_PORTS-1:0]                  dma_data_yumi_o,
  input  logic                                  order_ready_i,
  output logic                                  order_push_o,
  output port_id_t                              order_port_o,
  output mem_msg_s                              mem_cmd_o,
  output logic                                  mem_cmd_v_o,
  input  logic                                  mem_cmd_yumi_i
);

  localparam int CNT_W = $clog2(WORDS_PER_BLOCK);

  typedef enum logic [1:0] {
    ST_START,
    ST_IDLE,
    ST_GATHER,
    ST_SEND
  } req_state_e;

  dma_pkt_s [NUM_PORTS-1:0] pkt_head;
  logic [NUM_PORTS-1:0]     pkt_ready;
  logic [NUM_PORTS-1:0]     pkt_v;
  logic [NUM_PORTS-1:0]     pkt_yumi;

  req_state_e               state_r;
  req_state_e               state_n;
  port_id_t                 last_r;
  port_id_t                 port_r;
  port_id_t                 grant_id;
  logic                     grant_v;
  logic                     accept;
  logic                     take;
  logic [CNT_W-1:0]         count_r;
  dma_pkt_s                 pkt_r;
  logic [WORDS_PER_BLOCK-1:0][DATA_WIDTH-1:0] block_r;

  // Two entries per port hide the gap between address and write data
  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : g_pkt_fifo
    dma_fifo #(
      .payload_t (dma_pkt_s),
      .DEPTH     (2)
    ) u_pkt_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .data_i  (dma_pkt_i[i]),
      .v_i     (dma_pkt_v_i[i]),
      .ready_o (pkt_ready[i]),
      .data_o  (pkt_head[i]),
      .v_o     (pkt_v[i]),
      .yumi_i  (pkt_yumi[i])
    );
  end

  assign dma_pkt_yumi_o = dma_pkt_v_i & pkt_ready;

  // Search starts at the port after the one served last
  always_comb
  begin
    int unsigned idx;
    grant_v  = 1'b0;
    grant_id = '0;
    for (int k = NUM_PORTS; k >= 1; k--)
    begin
      idx = (int'(last_r) + k) % NUM_PORTS;
      if (pkt_v[idx])
      begin
        grant_v  = 1'b1;
        grant_id = port_id_t'(idx);
      end
    end
  end

  // Reads wait until the order queue can take their port
  assign accept = (state_r == ST_IDLE) & grant_v &
                  (pkt_head[grant_id].write_not_read | order_ready_i);

  always_comb
  begin
    pkt_yumi           = '0;
    pkt_yumi[grant_id] = accept;
  end

  assign order_push_o = accept & ~pkt_head[grant_id].write_not_read;
  assign order_port_o = grant_id;

  // Write data is steered from the port that won arbitration
  assign take = (state_r == ST_GATHER) & dma_data_v_i[port_r];

  always_comb
  begin
    dma_data_yumi_o         = '0;
    dma_data_yumi_o[port_r] = take;
  end

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      ST_START:
        state_n = ST_IDLE;
      ST_IDLE:
        if (accept)
          state_n = pkt_head[grant_id].write_not_read ? ST_GATHER : ST_SEND;
      ST_GATHER:
        if (take && count_r == CNT_W'(WORDS_PER_BLOCK - 1))
          state_n = ST_SEND;
      ST_SEND:
        if (mem_cmd_yumi_i)
          state_n = ST_IDLE;
      default:
        state_n = ST_START;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= ST_START;
      last_r  <= '0;
      port_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (accept)
      begin
        last_r  <= grant_id;
        port_r  <= grant_id;
        count_r <= '0;
      end
      else if (take)
        count_r <= count_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      pkt_r <= pkt_head[grant_id];
    if (take)
      block_r[count_r] <= dma_data_i[port_r];
  end

  assign mem_cmd_v_o        = (state_r == ST_SEND);
  assign mem_cmd_o.msg_type = pkt_r.write_not_read ? MEM_WRITE : MEM_READ;
  assign mem_cmd_o.addr     = {pkt_r.addr[CACHE_ADDR_WIDTH-1:BLOCK_OFFSET_WIDTH], port_r,
                               pkt_r.addr[BLOCK_OFFSET_WIDTH-1:0]};
  assign mem_cmd_o.data     = pkt_r.write_not_read ? block_r : '0;

  // Command must hold until memory takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && !mem_cmd_yumi_i) |=> (mem_cmd_v_o && $stable(mem_cmd_o)));

endmodule

`default_nettype wire

/* rtl/dma_fifo.sv */
// Small circular FIFO with a type parameter for its payload
// Push on v_i with ready_o, pop on yumi_i; head is visible on data_o
`timescale 1ns/1ns
`default_nettype none

module dma_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t           mem_r [DEPTH];
  logic [PTR_W-1:0]   rptr_r;
  logic [PTR_W-1:0]   wptr_r;
  logic [CNT_W-1:0]   count_r;
  logic [CNT_W-1:0]   count_n;
  logic               ready_r;
  logic               push;

  assign push    = v_i & ready_o;
  assign count_n = count_r + CNT_W'(push) - CNT_W'(yumi_i);

  assign ready_o = ready_r;
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rptr_r];

  // Ready is registered so it stays low while in reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      count_r <= '0;
      ready_r <= 1'b0;
    end
    else
    begin
      if (push)
        wptr_r <= (wptr_r == PTR_W'(DEPTH - 1)) ? '0 : wptr_r + 1'b1;
      if (yumi_i)
        rptr_r <= (rptr_r == PTR_W'(DEPTH - 1)) ? '0 : rptr_r + 1'b1;
      count_r <= count_n;
      ready_r <= (count_n != CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wptr_r] <= data_i;
  end

  // Consumer must not pop an empty buffer
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

  // Registered ready must keep pushes out of a full buffer
  assert property (@(posedge clk_i) disable iff (reset_i)
    push |-> (count_r != CNT_W'(DEPTH)));

endmodule

`default_nettype wire

/* rtl/mem_pkg.sv */
// Memory-side definitions for the DMA to memory bridge
// One message layout serves both commands and responses
`default_nettype none

package mem_pkg;

  import dma_pkg::*;

  // Port number sits just above the block offset
  localparam int MEM_ADDR_WIDTH = CACHE_ADDR_WIDTH + PORT_ID_WIDTH;
  localparam int BLOCK_WIDTH    = DATA_WIDTH * WORDS_PER_BLOCK;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_msg_type_e;

  typedef struct packed {
    mem_msg_type_e             msg_type;
    logic [MEM_ADDR_WIDTH-1:0] addr;
    logic [BLOCK_WIDTH-1:0]    data;
  } mem_msg_s;

endpackage

`default_nettype wire

/* rtl/dma_pkg.sv */
// Cache-side definitions for the DMA to memory bridge
// Port count, word and address widths, and the DMA packet layout
`default_nettype none

package dma_pkg;

  localparam int NUM_PORTS          = 2;
  localparam int PORT_ID_WIDTH      = 1;
  localparam int DATA_WIDTH         = 32;
  localparam int WORDS_PER_BLOCK    = 4;
  localparam int CACHE_ADDR_WIDTH   = 16;
  localparam int BLOCK_OFFSET_WIDTH = 4;

  typedef logic [PORT_ID_WIDTH-1:0] port_id_t;

  // One request from a cache DMA port
  typedef struct packed {
    logic                        write_not_read;
    logic [CACHE_ADDR_WIDTH-1:0] addr;
  } dma_pkt_s;

endpackage

`default_nettype wire
